//--- logic/game_vision_pkg.sv
package game_vision_pkg;

    // screen timing, 640x480 visible out of 800x525
    localparam int h_active = 640;
    localparam int h_total  = 800;
    localparam int v_active = 480;
    localparam int v_total  = 525;

    // pixels needed before the deciding pixel of a run
    localparam int collision_threshold = 19;
    // half width of the square hit box
    localparam int ball_half = 16;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
    } scan_pos_t;

    // rgb565
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel_t;

    typedef enum logic [1:0] {
        coll_idle = 2'd0,
        coll_run  = 2'd1,
        coll_calc = 2'd2
    } coll_state_t;

    typedef struct packed {
        logic   hit;
        coord_t center_x;
        coord_t speed;
        logic   detected;
    } collision_result_t;

    // register word addresses
    typedef enum logic [1:0] {
        reg_ball_pos  = 2'd0,
        reg_hit_count = 2'd1,
        reg_center    = 2'd2,
        reg_speed     = 2'd3
    } reg_addr_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- logic/vga_scan_counter.sv
`timescale 1ns/10ps

module vga_scan_counter
    import game_vision_pkg::*;
(
    input  logic      clk_25MHz,
    input  logic      reset,
    output scan_pos_t pos
);

    coord_t x_cnt;
    coord_t y_cnt;
    logic   x_last;
    logic   y_last;

    assign x_last = (x_cnt == coord_t'(h_total - 1));
    assign y_last = (y_cnt == coord_t'(v_total - 1));

    // horizontal counter, one pixel per clock
    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            x_cnt <= '0;
        end else if (x_last) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + coord_t'(1);
        end
    end

    // line counter steps at the end of each line
    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            y_cnt <= '0;
        end else if (x_last) begin
            if (y_last) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + coord_t'(1);
            end
        end
    end

    assign pos.x      = x_cnt;
    assign pos.y      = y_cnt;
    // visible area only
    assign pos.active = (x_cnt < coord_t'(h_active)) && (y_cnt < coord_t'(v_active));

endmodule

//--- logic/color_detector.sv
`timescale 1ns/10ps

module color_detector
    import game_vision_pkg::*;
(
    input  pixel_t pixel,
    output logic   target_color
);

    logic [3:0] r4;
    logic [3:0] g4;
    logic [3:0] b4;
    logic       dark_red;
    logic       bright_red;

    // top four bits of each field
    assign r4 = pixel.r[4:1];
    assign g4 = pixel.g[5:2];
    assign b4 = pixel.b[4:1];

    // dark band needs very low green and blue
    assign dark_red = (r4 >= 4'd10) && (r4 <= 4'd12) &&
                      (g4 <= 4'd3) && (b4 <= 4'd3);

    // bright band tolerates a little more
    assign bright_red = (r4 >= 4'd13) && (g4 <= 4'd5) && (b4 <= 4'd5);

    assign target_color = dark_red || bright_red;

endmodule

//--- logic/hit_area.sv
`timescale 1ns/10ps

module hit_area
    import game_vision_pkg::*;
(
    input  scan_pos_t pos,
    input  coord_t    ball_x,
    input  coord_t    ball_y,
    output logic      in_hit_area
);

    logic signed [11:0] x_s;
    logic signed [11:0] y_s;
    logic signed [11:0] x_lo;
    logic signed [11:0] x_hi;
    logic signed [11:0] y_lo;
    logic signed [11:0] y_hi;
    logic               x_in;
    logic               y_in;

    // signed and two bits wider, so the box may hang off the screen
    assign x_s = $signed({2'b00, pos.x});
    assign y_s = $signed({2'b00, pos.y});

    assign x_lo = $signed({2'b00, ball_x}) - 12'(ball_half);
    assign x_hi = $signed({2'b00, ball_x}) + 12'(ball_half);
    assign y_lo = $signed({2'b00, ball_y}) - 12'(ball_half);
    assign y_hi = $signed({2'b00, ball_y}) + 12'(ball_half);

    // inclusive on both sides
    assign x_in = (x_s >= x_lo) && (x_s <= x_hi);
    assign y_in = (y_s >= y_lo) && (y_s <= y_hi);

    assign in_hit_area = x_in && y_in;

endmodule

//--- logic/collision_detector.sv
`timescale 1ns/10ps

module collision_detector
    import game_vision_pkg::*;
(
    input  logic              clk_25MHz,
    input  logic              reset,
    input  scan_pos_t         pos,
    input  logic              in_hit_area,
    input  logic              target_color,
    output collision_result_t result
);

    coll_state_t state;
    coll_state_t state_next;

    logic [15:0] x_sum;
    logic [15:0] x_sum_next;
    logic [4:0]  count;
    logic [4:0]  count_next;
    coord_t      center_x;
    coord_t      center_x_next;
    coord_t      prev_center;
    coord_t      prev_center_next;
    coord_t      speed;
    coord_t      speed_next;
    logic        hit;
    logic        hit_next;
    logic        detected;
    logic        detected_next;
    logic        qualify;

    assign qualify = pos.active && in_hit_area && target_color;

    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            state       <= coll_idle;
            x_sum       <= '0;
            count       <= '0;
            center_x    <= '0;
            prev_center <= '0;
            speed       <= '0;
            hit         <= 1'b0;
            detected    <= 1'b0;
        end else begin
            state       <= state_next;
            x_sum       <= x_sum_next;
            count       <= count_next;
            center_x    <= center_x_next;
            prev_center <= prev_center_next;
            speed       <= speed_next;
            hit         <= hit_next;
            detected    <= detected_next;
        end
    end

    always_comb begin
        state_next       = state;
        x_sum_next       = x_sum;
        count_next       = count;
        center_x_next    = center_x;
        prev_center_next = prev_center;
        speed_next       = speed;
        hit_next         = 1'b0;
        detected_next    = detected;

        case (state)
            coll_idle: begin
                if (qualify) begin
                    x_sum_next = {6'b0, pos.x};
                    count_next = 5'd1;
                    state_next = coll_run;
                end else begin
                    detected_next = 1'b0;
                end
            end

            coll_run: begin
                if (!qualify) begin
                    // run broken before the threshold
                    state_next = coll_idle;
                end else if (count < 5'(collision_threshold)) begin
                    x_sum_next = x_sum + {6'b0, pos.x};
                    count_next = count + 5'd1;
                end else begin
                    // deciding pixel, its own x is not part of the mean
                    center_x_next = coord_t'(x_sum / 16'(collision_threshold));
                    detected_next = 1'b1;
                    state_next    = coll_calc;
                end
            end

            coll_calc: begin
                speed_next = (center_x >= prev_center) ? (center_x - prev_center)
                                                       : (prev_center - center_x);
                prev_center_next = center_x;
                hit_next         = 1'b1;
                count_next       = '0;
                state_next       = coll_idle;
            end

            default: begin
                state_next = coll_idle;
            end
        endcase
    end

    assign result.hit      = hit;
    assign result.center_x = center_x;
    assign result.speed    = speed;
    assign result.detected = detected;

endmodule

//--- logic/wb_game_regs.sv
`timescale 1ns/10ps

module wb_game_regs
    import game_vision_pkg::*;
(
    input  logic              clk_25MHz,
    input  logic              reset,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    input  collision_result_t result,
    output coord_t            ball_x,
    output coord_t            ball_y
);

    logic        ack;
    logic        req_new;
    logic [31:0] rd_dat;
    logic [31:0] hit_count;
    coord_t      last_center;
    coord_t      last_speed;

    // a new request is one not yet acknowledged
    assign req_new = wb_req.cyc && wb_req.stb && !ack;

    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req_new;
        end
    end

    // ball position, only writable register
    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            ball_x <= coord_t'(320);
            ball_y <= coord_t'(240);
        end else if (req_new && wb_req.we &&
                     reg_addr_t'(wb_req.adr) == reg_ball_pos) begin
            ball_x <= wb_req.dat[9:0];
            ball_y <= wb_req.dat[25:16];
        end
    end

    // speed and center are already settled when the pulse is seen
    always_ff @(posedge clk_25MHz or posedge reset) begin
        if (reset) begin
            hit_count   <= '0;
            last_center <= '0;
            last_speed  <= '0;
        end else if (result.hit) begin
            hit_count   <= hit_count + 32'd1;
            last_center <= result.center_x;
            last_speed  <= result.speed;
        end
    end

    // read data sampled with the request, held while ack is high
    always_ff @(posedge clk_25MHz) begin
        if (req_new) begin
            case (reg_addr_t'(wb_req.adr))
                reg_ball_pos:  rd_dat <= {6'b0, ball_y, 6'b0, ball_x};
                reg_hit_count: rd_dat <= hit_count;
                reg_center:    rd_dat <= {22'b0, last_center};
                reg_speed:     rd_dat <= {22'b0, last_speed};
                default:       rd_dat <= '0;
            endcase
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

endmodule

//--- logic/game_vision_top.sv
`timescale 1ns/10ps

module game_vision_top
    import game_vision_pkg::*;
(
    input  logic              clk_25MHz,
    input  logic              reset,
    input  pixel_t            camera_pixel,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    output scan_pos_t         pos,
    output collision_result_t result
);

    logic   target_color;
    logic   in_hit_area;
    coord_t ball_x;
    coord_t ball_y;

    vga_scan_counter u_scan (
        .clk_25MHz (clk_25MHz),
        .reset     (reset),
        .pos       (pos)
    );

    color_detector u_color (
        .pixel        (camera_pixel),
        .target_color (target_color)
    );

    hit_area u_hit_area (
        .pos         (pos),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .in_hit_area (in_hit_area)
    );

    collision_detector u_collision (
        .clk_25MHz    (clk_25MHz),
        .reset        (reset),
        .pos          (pos),
        .in_hit_area  (in_hit_area),
        .target_color (target_color),
        .result       (result)
    );

    wb_game_regs u_regs (
        .clk_25MHz (clk_25MHz),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .result    (result),
        .ball_x    (ball_x),
        .ball_y    (ball_y)
    );

endmodule

//--- sim/game_vision_asserts.sv
`timescale 1ns/10ps

module game_vision_asserts (
    input logic clk_25MHz,
    input logic reset,
    input logic ack,
    input logic hit,
    input logic detected,
    input logic in_calc
);

    assert property (@(posedge clk_25MHz) disable iff (reset) ack |=> !ack)
        else $error("ack high for two consecutive cycles");

    assert property (@(posedge clk_25MHz) disable iff (reset) hit |=> !hit)
        else $error("hit pulse longer than one cycle");

    // pulse lands on the cycle after coll_calc is entered
    assert property (@(posedge clk_25MHz) disable iff (reset) $rose(in_calc) |=> hit)
        else $error("no hit pulse after entering coll_calc");

    assert property (@(posedge clk_25MHz) disable iff (reset) hit |-> $past(in_calc))
        else $error("hit pulse without coll_calc");

    assert property (@(posedge clk_25MHz) $fell(reset) |-> !ack && !hit && !detected)
        else $error("outputs not low after reset");

endmodule

bind collision_detector game_vision_asserts coll_checks (
    .clk_25MHz (clk_25MHz), .reset (reset), .ack (1'b0),
    .hit (hit), .detected (detected), .in_calc (state == coll_calc)
);

// bus side only carries ack
bind wb_game_regs game_vision_asserts bus_checks (
    .clk_25MHz (clk_25MHz), .reset (reset), .ack (ack),
    .hit (1'b0), .detected (1'b0), .in_calc (1'b0)
);

//--- sim/game_vision_tb.sv
`timescale 1ns/10ps

module game_vision_tb
    import game_vision_pkg::*;
();

    typedef logic [31:0] wb_data_t;

    logic              clk_25MHz;
    logic              reset;
    pixel_t            camera_pixel;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    scan_pos_t         pos;
    collision_result_t result;

    // red runs of the current scene
    int          run_cnt;
    int          run_y [4];
    int          run_x0 [4];
    int          run_len [4];
    pixel_t      run_pix [4];

    // reference model state and the ball position it assumes
    coll_state_t       m_state;
    int                m_sum;
    int                m_count;
    int                m_prev;
    int                m_hits;
    int                ball_x;
    int                ball_y;
    collision_result_t exp_q [$];

    // expected scan position
    int          scan_x;
    int          scan_y;
    scan_pos_t   exp_pos;

    int          hits_seen;
    int          errors;
    int          errors_before;
    int          tests;
    logic [31:0] rng;
    wb_data_t    rd;

    game_vision_top dut0 (
        .clk_25MHz    (clk_25MHz),
        .reset        (reset),
        .camera_pixel (camera_pixel),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .pos          (pos),
        .result       (result)
    );

    always #20 clk_25MHz = ~clk_25MHz;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic is_red(pixel_t p);
        if (p.r[4:1] >= 4'd13) begin
            return (p.g[5:2] <= 4'd5) && (p.b[4:1] <= 4'd5);
        end
        return (p.r[4:1] >= 4'd10) && (p.g[5:2] <= 4'd3) && (p.b[4:1] <= 4'd3);
    endfunction

    function automatic pixel_t scene_pixel(scan_pos_t p);
        pixel_t pix;
        int     i;
        // dim grey background
        pix = 16'h0841;
        for (i = 0; i < run_cnt; i++) begin
            if (int'(p.y) == run_y[i] && int'(p.x) >= run_x0[i] &&
                int'(p.x) < run_x0[i] + run_len[i]) begin
                pix = run_pix[i];
            end
        end
        return pix;
    endfunction

    // one step of the run rule per observed pixel, queues each predicted hit
    function automatic void step_model(scan_pos_t p, pixel_t pix);
        logic              q;
        int                center;
        collision_result_t e;
        q = p.active && is_red(pix) &&
            int'(p.x) >= ball_x - ball_half && int'(p.x) <= ball_x + ball_half &&
            int'(p.y) >= ball_y - ball_half && int'(p.y) <= ball_y + ball_half;
        if (m_state == coll_idle && q) begin
            m_sum   = int'(p.x);
            m_count = 1;
            m_state = coll_run;
        end else if (m_state == coll_run && !q) begin
            m_state = coll_idle;
        end else if (m_state == coll_run && m_count < collision_threshold) begin
            m_sum   = m_sum + int'(p.x);
            m_count = m_count + 1;
        end else if (m_state == coll_run) begin
            center     = m_sum / collision_threshold;
            e.hit      = 1'b1;
            e.center_x = coord_t'(center);
            e.speed    = coord_t'((center >= m_prev) ? center - m_prev : m_prev - center);
            e.detected = 1'b1;
            exp_q.push_back(e);
            m_prev  = center;
            m_hits  = m_hits + 1;
            m_state = coll_calc;
        end else if (m_state == coll_calc) begin
            // the pixel seen during the calc cycle is dropped
            m_state = coll_idle;
        end
    endfunction

    task automatic compare_result(collision_result_t exp, collision_result_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: result expected hit=%0b center=%0d speed=%0d det=%0b, %s",
                     $time, exp.hit, exp.center_x, exp.speed, exp.detected,
                     $sformatf("actual hit=%0b center=%0d speed=%0d det=%0b",
                               act.hit, act.center_x, act.speed, act.detected));
            errors++;
        end
    endtask

    task automatic compare_pos(scan_pos_t exp, scan_pos_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: pos expected x=%0d y=%0d active=%0b, %s",
                     $time, exp.x, exp.y, exp.active,
                     $sformatf("actual x=%0d y=%0d active=%0b",
                               act.x, act.y, act.active));
            errors++;
        end
    endtask

    task automatic compare_word(string name, wb_data_t exp, wb_data_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout at %0t: no %s within the allowed cycles", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic bus_access(logic we, reg_addr_t adr, wb_data_t dat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        n = 0;
        do begin
            @(posedge clk_25MHz);
            #2;
            n++;
            if (n > 16) begin
                report_timeout("Wishbone ack");
            end
        end while (!wb_rsp.ack);
        rd     = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic check_reg(reg_addr_t adr, wb_data_t exp, string name);
        bus_access(1'b0, adr, '0);
        compare_word(name, exp, rd);
    endtask

    task automatic move_ball(int x, int y);
        bus_access(1'b1, reg_ball_pos, {6'd0, 10'(y), 6'd0, 10'(x)});
        ball_x = x;
        ball_y = y;
    endtask

    task automatic add_run(int y, int x0, int len, pixel_t pix);
        run_y[run_cnt]   = y;
        run_x0[run_cnt]  = x0;
        run_len[run_cnt] = len;
        run_pix[run_cnt] = pix;
        run_cnt++;
    endtask

    task automatic wait_row(int y);
        int n;
        n = 0;
        while (int'(pos.y) != y) begin
            @(posedge clk_25MHz);
            #2;
            n++;
            if (n > 2 * h_total * v_total) begin
                report_timeout("scan line");
            end
        end
    endtask

    task automatic wait_hits(int target);
        int n;
        n = 0;
        while (hits_seen < target) begin
            @(posedge clk_25MHz);
            #2;
            n++;
            if (n > 2 * h_total * v_total) begin
                report_timeout("hit event");
            end
        end
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    always @(posedge clk_25MHz) begin
        #2;
        camera_pixel = scene_pixel(pos);
    end

    // scan position and hit events checked mid-cycle against the model
    always @(negedge clk_25MHz) begin
        if (!reset) begin
            exp_pos.x      = coord_t'(scan_x);
            exp_pos.y      = coord_t'(scan_y);
            exp_pos.active = (scan_x < h_active) && (scan_y < v_active);
            compare_pos(exp_pos, pos);
            scan_x++;
            if (scan_x == h_total) begin
                scan_x = 0;
                scan_y = (scan_y + 1) % v_total;
            end
            step_model(pos, camera_pixel);
            if (result.hit) begin
                hits_seen++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected hit event at %0t with center %0d", $time,
                             result.center_x);
                    errors++;
                end else begin
                    compare_result(exp_q.pop_front(), result);
                end
            end
        end
    end

    initial begin
        int     f;
        int     i;
        int     bx;
        int     by;
        pixel_t pix;
        clk_25MHz     = 1'b0;
        reset         = 1'b1;
        camera_pixel  = '0;
        wb_req        = '0;
        run_cnt       = 0;
        m_state       = coll_idle;
        m_sum         = 0;
        m_count       = 0;
        m_prev        = 0;
        m_hits        = 0;
        ball_x        = 320;
        ball_y        = 240;
        scan_x        = 0;
        scan_y        = 0;
        exp_pos       = '0;
        hits_seen     = 0;
        errors        = 0;
        errors_before = 0;
        tests         = 0;
        rng           = 32'h1521_7e62;
        repeat (2) @(posedge clk_25MHz);
        #2;
        reset = 1'b0;

        check_reg(reg_ball_pos, {6'd0, 10'd240, 6'd0, 10'd320}, "reg_ball_pos");
        move_ball(200, 100);
        check_reg(reg_ball_pos, {6'd0, 10'd100, 6'd0, 10'd200}, "reg_ball_pos");
        bus_access(1'b1, reg_speed, 32'h0000_03ff);
        check_reg(reg_speed, 32'd0, "reg_speed");
        finish_test("register access");

        wait_row(v_active);
        add_run(100, 190, 25, 16'hf882);
        wait_hits(1);
        wait_row(v_active);
        run_cnt = 0;
        check_reg(reg_hit_count, 32'd1, "reg_hit_count");
        check_reg(reg_center, 32'd199, "reg_center");
        check_reg(reg_speed, 32'd199, "reg_speed");
        finish_test("single hit");

        // short run, run off the box, red too dim, green too strong
        add_run(100, 190, 18, 16'hf882);
        add_run(300, 190, 25, 16'hf882);
        add_run(104, 190, 25, 16'h9000);
        add_run(110, 190, 25, 16'hfb00);
        wait_row(0);
        wait_row(v_active);
        run_cnt = 0;
        compare_word("hits_seen", 32'd1, wb_data_t'(hits_seen));
        check_reg(reg_hit_count, 32'd1, "reg_hit_count");
        finish_test("rejection");

        move_ball(400, 200);
        add_run(200, 395, 22, 16'hb104);
        wait_hits(2);
        wait_row(v_active);
        run_cnt = 0;
        check_reg(reg_center, 32'd404, "reg_center");
        check_reg(reg_speed, 32'd205, "reg_speed");
        check_reg(reg_hit_count, 32'd2, "reg_hit_count");
        finish_test("speed");

        for (f = 0; f < 3; f++) begin
            rng = xorshift(rng);
            bx  = 40 + int'(rng % 560);
            rng = xorshift(rng);
            by  = 40 + int'(rng % 400);
            move_ball(bx, by);
            for (i = 0; i < 4; i++) begin
                rng = xorshift(rng);
                pix = {1'b1, rng[27:24], 1'b0, rng[22:18], 1'b0, rng[31:28]};
                add_run(by - 20 + int'(rng[7:0]) % 41, bx - 30 + int'(rng[15:8]) % 41,
                        10 + int'(rng[23:16]) % 24, pix);
            end
            wait_row(0);
            wait_row(v_active);
            run_cnt = 0;
        end
        check_reg(reg_hit_count, wb_data_t'(m_hits), "reg_hit_count");
        compare_word("hits_seen", wb_data_t'(m_hits), wb_data_t'(hits_seen));
        compare_word("pending hits", 32'd0, wb_data_t'(exp_q.size()));
        finish_test("random scenes");

        $display("%0d tests, %0d hits, %0d errors", tests, hits_seen, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/game_vision_pkg.sv
logic/vga_scan_counter.sv
logic/color_detector.sv
logic/hit_area.sv
logic/collision_detector.sv
logic/wb_game_regs.sv
logic/game_vision_top.sv
sim/game_vision_asserts.sv
sim/game_vision_tb.sv

//--- Bender.yml
package:
  name: game_vision

sources:
  - logic/game_vision_pkg.sv
  - logic/vga_scan_counter.sv
  - logic/color_detector.sv
  - logic/hit_area.sv
  - logic/collision_detector.sv
  - logic/wb_game_regs.sv
  - logic/game_vision_top.sv
  - target: simulation
    files:
      - sim/game_vision_asserts.sv
      - sim/game_vision_tb.sv
